// File: src/clockDisplayPkg.sv
package clockDisplayPkg;

	////////////////////////////////////////////////////////////
	// Time values as the host writes them

	typedef struct packed {
		logic [7:0] hi;  // Day or hours, byte 0
		logic [7:0] mid; // Month or minutes
		logic [7:0] lo;  // Year or seconds
	} bcdTriple;

	typedef struct packed {
		bcdTriple date;  // Row 0
		bcdTriple clock; // Row 1
		bcdTriple timer; // Row 2, countdown
		logic     alarm; // Shows the alarm icon
	} displayTime;

	////////////////////////////////////////////////////////////
	// APB host port, paddr is a word index

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [3:0]  paddr;
		logic [31:0] pwdata;
	} apbReq;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apbRsp;

	////////////////////////////////////////////////////////////
	// Pixel pipeline records

	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic       active; // Inside visible area
		logic       hsync;  // Active low
		logic       vsync;  // Active low
	} pixelPos;

	typedef enum logic [1:0] {
		Outside,
		Panel,
		Digit,
		AlarmIcon
	} fieldKind;

	typedef struct packed {
		fieldKind   kind;
		logic [1:0] row;  // 0 date, 1 clock, 2 timer
		logic [2:0] slot; // Digit position in the row
		logic [4:0] lx;   // Offset inside the cell
		logic [4:0] ly;
		logic       active;
		logic       hsync;
		logic       vsync;
	} cellHit;

	// 12-bit RGB, 4 bits per channel
	localparam logic [11:0] PanelColor = 12'h223;
	localparam logic [11:0] SegColor   = 12'hFD2;
	localparam logic [11:0] AlarmColor = 12'hF20;

	localparam int SegThick = 2; // Segment stroke in pixels

	// Bit 6 is segment a down to bit 0 segment g
	localparam logic [6:0] segTable [0:9] = '{
		7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33,
		7'h5B, 7'h5F, 7'h70, 7'h7F, 7'h7B
	};

endpackage

// File: src/vgaTiming.sv
`timescale 1ns/1ps

module vgaTiming #(
	parameter int HActive = 640,
	parameter int HFront  = 16,
	parameter int HSync   = 96,
	parameter int HBack   = 48,
	parameter int VActive = 480,
	parameter int VFront  = 10,
	parameter int VSync   = 2,
	parameter int VBack   = 33
) (
	input  logic                     CLK,
	input  logic                     reset,
	output clockDisplayPkg::pixelPos pos
);

	localparam int HTotal = HActive + HFront + HSync + HBack;
	localparam int VTotal = VActive + VFront + VSync + VBack;

	localparam logic [9:0] HLast      = 10'(HTotal - 1);
	localparam logic [9:0] VLast      = 10'(VTotal - 1);
	localparam logic [9:0] HActEnd    = 10'(HActive);
	localparam logic [9:0] VActEnd    = 10'(VActive);
	localparam logic [9:0] HSyncStart = 10'(HActive + HFront);
	localparam logic [9:0] HSyncEnd   = 10'(HActive + HFront + HSync);
	localparam logic [9:0] VSyncStart = 10'(VActive + VFront);
	localparam logic [9:0] VSyncEnd   = 10'(VActive + VFront + VSync);

	logic [9:0] hCount; // Pixel within the line
	logic [9:0] vCount; // Line within the frame

	always_ff @(posedge CLK) begin
		if (reset) begin
			hCount <= '0;
			vCount <= '0;
		end else if (hCount == HLast) begin
			hCount <= '0; // End of line, step the line counter
			if (vCount == VLast)
				vCount <= '0;
			else
				vCount <= vCount + 10'd1;
		end else begin
			hCount <= hCount + 10'd1;
		end
	end

	always_comb begin
		pos.x      = hCount;
		pos.y      = vCount;
		pos.active = (hCount < HActEnd) && (vCount < VActEnd);
		pos.hsync  = !((hCount >= HSyncStart) && (hCount < HSyncEnd)); // Low in sync window
		pos.vsync  = !((vCount >= VSyncStart) && (vCount < VSyncEnd));
	end

	// Line length must come from the wrap compare, never from overflow
	assert property (@(posedge CLK) disable iff (reset) hCount <= HLast)
		else $error("vgaTiming: horizontal counter beyond line total");

endmodule

// File: src/fieldDecoder.sv
`timescale 1ns/1ps

module fieldDecoder #(
	parameter int PanelX = 200,
	parameter int PanelY = 150,
	parameter int CellW  = 24,
	parameter int CellH  = 30
) (
	input  logic                     CLK,
	input  logic                     reset,
	input  clockDisplayPkg::pixelPos pos,
	output clockDisplayPkg::cellHit  hit
);
	import clockDisplayPkg::*;

	// Panel is 10 cells wide and 6 cells high
	localparam logic [9:0] Left     = 10'(PanelX);
	localparam logic [9:0] Right    = 10'(PanelX + 10 * CellW);
	localparam logic [9:0] Top      = 10'(PanelY);
	localparam logic [9:0] Bottom   = 10'(PanelY + 6 * CellH);
	localparam logic [9:0] Wd       = 10'(CellW);
	localparam logic [9:0] Ht       = 10'(CellH);
	localparam logic [9:0] HalfHt   = 10'(CellH / 2); // First row starts half a cell down
	localparam logic [9:0] RowPitch = 10'(2 * CellH); // Rows one cell apart

	logic       inPanel;
	logic [9:0] relX;    // Offset from panel corner
	logic [9:0] relY;
	logic [9:0] rowOff;  // Offset from top of row 0
	logic [9:0] colIdx;  // Grid column 0 to 9
	logic [9:0] rowIdx;
	logic [9:0] inX;
	logic [9:0] inY;
	logic [9:0] digCol;  // Digit column c, one left of the grid column
	logic [9:0] slotIdx;
	logic       inRow;
	logic       isDigit;
	logic       isAlarm;
	fieldKind   kindNext;

	always_comb begin
		inPanel = pos.active && (pos.x >= Left) && (pos.x < Right)
			&& (pos.y >= Top) && (pos.y < Bottom);
		relX   = pos.x - Left;
		relY   = pos.y - Top;
		rowOff = relY - HalfHt;
		colIdx = relX / Wd;
		inX    = relX % Wd;
		rowIdx = rowOff / RowPitch;
		inY    = rowOff % RowPitch; // Lower half of the pitch is the gap
		inRow  = (relY >= HalfHt) && (rowIdx < 10'd3) && (inY < Ht);

		// Digits sit at c = 0,1,3,4,6,7, every third column is a separator
		digCol  = colIdx - 10'd1;
		slotIdx = digCol - digCol / 10'd3;
		isDigit = inRow && (colIdx >= 10'd1) && (colIdx <= 10'd8)
			&& (digCol % 10'd3 != 10'd2);
		isAlarm = inRow && (rowIdx == 10'd0) && (colIdx == 10'd9); // Last grid cell of row 0

		if (!inPanel)
			kindNext = Outside;
		else if (isDigit)
			kindNext = Digit;
		else if (isAlarm)
			kindNext = AlarmIcon;
		else
			kindNext = Panel;
	end

	always_ff @(posedge CLK) begin
		hit.row  <= rowIdx[1:0];  // Cell payload
		hit.slot <= slotIdx[2:0];
		hit.lx   <= inX[4:0];
		hit.ly   <= inY[4:0];
		if (reset) begin
			hit.kind   <= Outside;
			hit.active <= 1'b0;
			hit.hsync  <= 1'b1; // Syncs idle high
			hit.vsync  <= 1'b1;
		end else begin
			hit.kind   <= kindNext;
			hit.active <= pos.active;
			hit.hsync  <= pos.hsync;
			hit.vsync  <= pos.vsync;
		end
	end

	// Renderer indexes the time registers with row and slot
	assert property (@(posedge CLK) disable iff (reset)
		(hit.kind == Digit) |-> (hit.row < 2'd3) && (hit.slot < 3'd6))
		else $error("fieldDecoder: digit hit outside the 3x6 grid");

endmodule

// File: src/timeRegisters.sv
`timescale 1ns/1ps

module timeRegisters (
	input  logic                        CLK,
	input  logic                        reset,
	input  clockDisplayPkg::apbReq      req,
	output clockDisplayPkg::apbRsp      rsp,
	output clockDisplayPkg::displayTime timeVals
);

	////////////////////////////////////////////////////////////
	// Register map, word index
	//   0 date   bits 23:0
	//   1 clock  bits 23:0
	//   2 timer  bits 23:0
	//   3 ctrl   bit 0 alarm

	logic        access;   // APB access phase
	logic        addrOk;
	logic [31:0] readWord;

	assign access = req.psel && req.penable;
	assign addrOk = (req.paddr <= 4'd3);

	always_ff @(posedge CLK) begin
		if (reset) begin
			timeVals <= '0;
		end else if (access && req.pwrite && addrOk) begin
			case (req.paddr[1:0]) // Write lands on the edge ending access
				2'd0:    timeVals.date  <= req.pwdata[23:0];
				2'd1:    timeVals.clock <= req.pwdata[23:0];
				2'd2:    timeVals.timer <= req.pwdata[23:0];
				default: timeVals.alarm <= req.pwdata[0];
			endcase
		end
	end

	always_comb begin
		case (req.paddr)
			4'd0:    readWord = {8'h00, timeVals.date};
			4'd1:    readWord = {8'h00, timeVals.clock};
			4'd2:    readWord = {8'h00, timeVals.timer};
			4'd3:    readWord = {31'd0, timeVals.alarm};
			default: readWord = 32'd0; // Unmapped reads as zero
		endcase
	end

	////////////////////////////////////////////////////////////
	// Response, never stalls

	assign rsp.prdata  = (access && !req.pwrite) ? readWord : 32'd0;
	assign rsp.pready  = 1'b1;
	assign rsp.pslverr = access && !addrOk;

	// Host must open every transfer with a setup phase
	assert property (@(posedge CLK) disable iff (reset)
		$rose(req.penable) |-> req.psel && $past(req.psel && !req.penable))
		else $error("timeRegisters: penable without a setup phase");

endmodule

// File: src/glyphRenderer.sv
`timescale 1ns/1ps

module glyphRenderer #(
	parameter int CellW = 24,
	parameter int CellH = 30
) (
	input  logic                        CLK,
	input  logic                        reset,
	input  clockDisplayPkg::cellHit     hit,
	input  clockDisplayPkg::displayTime timeVals,
	output logic [11:0]                 color,
	output logic                        hs,
	output logic                        vs
);
	import clockDisplayPkg::*;

	// Segment bands in cell coordinates
	localparam logic [4:0] Thick  = 5'(SegThick);
	localparam logic [4:0] Mid    = 5'(CellH / 2);
	localparam logic [4:0] MidUp  = 5'(CellH / 2 - 1);  // g is two lines, mid-1 and mid
	localparam logic [4:0] Bottom = 5'(CellH - SegThick);
	localparam logic [4:0] Right  = 5'(CellW - SegThick);

	bcdTriple    rowVal;
	logic [3:0]  nibble;
	logic [6:0]  segOn;   // Lit by the digit, a in bit 6
	logic [6:0]  segHere; // Covering this pixel
	logic [11:0] colorNext;

	////////////////////////////////////////////////////////////
	// Digit select and segment test

	always_comb begin
		case (hit.row)
			2'd0:    rowVal = timeVals.date;
			2'd1:    rowVal = timeVals.clock;
			default: rowVal = timeVals.timer;
		endcase

		// Even slot takes the high nibble of its byte
		case (hit.slot)
			3'd0:    nibble = rowVal.hi[7:4];
			3'd1:    nibble = rowVal.hi[3:0];
			3'd2:    nibble = rowVal.mid[7:4];
			3'd3:    nibble = rowVal.mid[3:0];
			3'd4:    nibble = rowVal.lo[7:4];
			default: nibble = rowVal.lo[3:0];
		endcase

		segOn = (nibble > 4'd9) ? 7'd0 : segTable[nibble]; // Non-BCD stays blank

		segHere[6] = hit.ly < Thick;                         // a
		segHere[5] = (hit.lx >= Right) && (hit.ly < Mid);    // b
		segHere[4] = (hit.lx >= Right) && (hit.ly >= Mid);   // c
		segHere[3] = hit.ly >= Bottom;                       // d
		segHere[2] = (hit.lx < Thick) && (hit.ly >= Mid);    // e
		segHere[1] = (hit.lx < Thick) && (hit.ly < Mid);     // f
		segHere[0] = (hit.ly == MidUp) || (hit.ly == Mid);   // g

		colorNext = 12'h000; // Blanking
		if (hit.active) begin
			case (hit.kind)
				Digit:     colorNext = |(segOn & segHere) ? SegColor : PanelColor;
				AlarmIcon: colorNext = timeVals.alarm ? AlarmColor : PanelColor;
				Panel:     colorNext = PanelColor;
				default:   colorNext = 12'h000;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Output stage, syncs follow the colour

	always_ff @(posedge CLK) begin
		if (reset) begin
			color <= 12'h000;
			hs    <= 1'b1;
			vs    <= 1'b1;
		end else begin
			color <= colorNext;
			hs    <= hit.hsync;
			vs    <= hit.vsync;
		end
	end

endmodule

// File: src/clockDisplay.sv
`timescale 1ns/1ps

module clockDisplay #(
	// 640x480 at 60 Hz from a 25 MHz pixel clock
	parameter int HActive = 640,
	parameter int HFront  = 16,
	parameter int HSync   = 96,
	parameter int HBack   = 48,
	parameter int VActive = 480,
	parameter int VFront  = 10,
	parameter int VSync   = 2,
	parameter int VBack   = 33,
	parameter int PanelX  = 200, // Panel corner on screen
	parameter int PanelY  = 150,
	parameter int CellW   = 24,  // Up to 32, local offsets are 5 bits
	parameter int CellH   = 30
) (
	input  logic                   CLK,
	input  logic                   reset,
	input  clockDisplayPkg::apbReq apbIn,
	output clockDisplayPkg::apbRsp apbOut,
	output logic [11:0]            COLOR_OUT,
	output logic                   HS,
	output logic                   VS
);
	import clockDisplayPkg::*;

	pixelPos    pos;      // Cycle t, from the counters
	cellHit     hit;      // Cycle t+1
	displayTime timeVals; // Host-written values

	vgaTiming #(
		.HActive(HActive), .HFront(HFront), .HSync(HSync), .HBack(HBack),
		.VActive(VActive), .VFront(VFront), .VSync(VSync), .VBack(VBack)
	) u_vgaTiming (
		.CLK  (CLK),
		.reset(reset),
		.pos  (pos)
	);

	fieldDecoder #(
		.PanelX(PanelX), .PanelY(PanelY), .CellW(CellW), .CellH(CellH)
	) u_fieldDecoder (
		.CLK  (CLK),
		.reset(reset),
		.pos  (pos),
		.hit  (hit)
	);

	timeRegisters u_timeRegisters (
		.CLK     (CLK),
		.reset   (reset),
		.req     (apbIn),
		.rsp     (apbOut),
		.timeVals(timeVals)
	);

	// Colour and syncs leave at t+2
	glyphRenderer #(
		.CellW(CellW), .CellH(CellH)
	) u_glyphRenderer (
		.CLK     (CLK),
		.reset   (reset),
		.hit     (hit),
		.timeVals(timeVals),
		.color   (COLOR_OUT),
		.hs      (HS),
		.vs      (VS)
	);

endmodule

// File: bench/tbClockDisplay.sv
`timescale 1ns/1ps

module tbClockDisplay;
	import clockDisplayPkg::*;

	////////////////////////////////////////////////////////////
	// Small frame so a run stays short

	localparam int HAct = 96;
	localparam int HFr  = 4;
	localparam int HSy  = 8;
	localparam int HBk  = 4;
	localparam int VAct = 64;
	localparam int VFr  = 2;
	localparam int VSy  = 2;
	localparam int VBk  = 2;
	localparam int PanX = 8;  // Panel spans x 8..87
	localparam int PanY = 8;  // and y 8..55
	localparam int CW   = 8;
	localparam int CH   = 8;
	localparam int HTot = HAct + HFr + HSy + HBk;      // 112 cycles per line
	localparam int VTot = VAct + VFr + VSy + VBk;      // 70 lines
	localparam int FrameCycles   = HTot * VTot;
	localparam int TimeoutCycles = 6 * FrameCycles + 500; // Six frames of tests plus APB traffic

	logic        CLK;
	logic        reset;
	apbReq       apbIn;
	apbRsp       apbOut;
	logic [11:0] colorOut;
	logic        hsPin;
	logic        vsPin;

	int          errCount = 0;
	int          testsPassed = 0;
	int          testsFailed = 0;
	int          testErrStart = 0;
	int          cycleCount = 0;
	logic [31:0] rngState = 32'd84; // LCG seed

	// Model registers, follow the APB writes
	logic [23:0] regDate;
	logic [23:0] regClock;
	logic [23:0] regTimer;
	logic        regAlarm;

	// Reference pipeline, mirrors counters then two stages
	int          mH;
	int          mV;
	int          p1X;
	int          p1Y;
	int          outX;   // Coordinate now on the pins
	int          outY;
	logic        p1Valid;
	logic [11:0] expColor;
	logic        expHs;
	logic        expVs;

	clockDisplay #(
		.HActive(HAct), .HFront(HFr), .HSync(HSy), .HBack(HBk),
		.VActive(VAct), .VFront(VFr), .VSync(VSy), .VBack(VBk),
		.PanelX(PanX), .PanelY(PanY), .CellW(CW), .CellH(CH)
	) u_clockDisplay (
		.CLK      (CLK),
		.reset    (reset),
		.apbIn    (apbIn),
		.apbOut   (apbOut),
		.COLOR_OUT(colorOut),
		.HS       (hsPin),
		.VS       (vsPin)
	);

	initial CLK = 1'b0;
	always #4 CLK = ~CLK; // 8 ns period

	always @(posedge CLK) cycleCount <= cycleCount + 1;

	////////////////////////////////////////////////////////////
	// Reference model of layout, segments and colour

	// Segments a..g in bits 6..0
	function automatic logic [6:0] segmentsOf(logic [3:0] d);
		case (d)
			4'd0:    return 7'b1111110;
			4'd1:    return 7'b0110000;
			4'd2:    return 7'b1101101;
			4'd3:    return 7'b1111001;
			4'd4:    return 7'b0110011;
			4'd5:    return 7'b1011011;
			4'd6:    return 7'b1011111;
			4'd7:    return 7'b1110000;
			4'd8:    return 7'b1111111;
			4'd9:    return 7'b1111011;
			default: return 7'b0000000; // Above 9 is blank
		endcase
	endfunction

	function automatic logic segmentCovers(logic [6:0] segs, int lx, int ly);
		logic [6:0] here;
		int         mid;
		mid = CH / 2;
		here[6] = ly < SegThick;                              // a
		here[5] = (lx >= CW - SegThick) && (ly < mid);        // b
		here[4] = (lx >= CW - SegThick) && (ly >= mid);       // c
		here[3] = ly >= CH - SegThick;                        // d
		here[2] = (lx < SegThick) && (ly >= mid);             // e
		here[1] = (lx < SegThick) && (ly < mid);              // f
		here[0] = (ly == mid - 1) || (ly == mid);             // g
		return |(segs & here);
	endfunction

	function automatic logic [11:0] expectedColor(int x, int y);
		int          r;
		int          k;
		int          left;
		int          top;
		logic [23:0] val;
		logic [3:0]  nib;
		logic [11:0] color;
		color = PanelColor;
		if (x >= HAct || y >= VAct || x < PanX || x >= PanX + 10 * CW
			|| y < PanY || y >= PanY + 6 * CH)
			color = 12'h000; // Blanking or off the panel
		else if (x >= PanX + 9 * CW && y >= PanY + CH / 2 && y < PanY + CH / 2 + CH)
			color = regAlarm ? AlarmColor : PanelColor; // Alarm cell, row 0
		else begin
			for (r = 0; r < 3; r++) begin
				for (k = 0; k < 6; k++) begin
					left = PanX + CW * (k + k / 2 + 1);
					top  = PanY + CH / 2 + r * 2 * CH;
					if (x >= left && x < left + CW && y >= top && y < top + CH) begin
						val = (r == 0) ? regDate : (r == 1) ? regClock : regTimer;
						nib = val[23 - 4 * k -: 4]; // Byte 0 high nibble first
						if (segmentCovers(segmentsOf(nib), x - left, y - top))
							color = SegColor;
					end
				end
			end
		end
		return color;
	endfunction

	function automatic logic hsyncLevel(int x);
		return !((x >= HAct + HFr) && (x < HAct + HFr + HSy)); // Low in the sync window
	endfunction

	function automatic logic vsyncLevel(int y);
		return !((y >= VAct + VFr) && (y < VAct + VFr + VSy));
	endfunction

	always @(posedge CLK) begin
		if (reset) begin
			mH       <= 0;
			mV       <= 0;
			p1Valid  <= 1'b0;
			expColor <= 12'h000;
			expHs    <= 1'b1;
			expVs    <= 1'b1;
		end else begin
			if (mH == HTot - 1) begin
				mH <= 0;
				mV <= (mV == VTot - 1) ? 0 : mV + 1;
			end else begin
				mH <= mH + 1;
			end
			p1X     <= mH; // Decoder stage
			p1Y     <= mV;
			p1Valid <= 1'b1;
			outX    <= p1X;
			outY    <= p1Y;
			if (p1Valid) begin
				expColor <= expectedColor(p1X, p1Y);
				expHs    <= hsyncLevel(p1X);
				expVs    <= vsyncLevel(p1Y);
			end
		end
	end

	always @(posedge CLK) begin
		if (reset) begin
			regDate  <= '0;
			regClock <= '0;
			regTimer <= '0;
			regAlarm <= 1'b0;
		end else if (apbIn.psel && apbIn.penable && apbIn.pwrite) begin
			case (apbIn.paddr) // Lands on the access edge
				4'd0:    regDate  <= apbIn.pwdata[23:0];
				4'd1:    regClock <= apbIn.pwdata[23:0];
				4'd2:    regTimer <= apbIn.pwdata[23:0];
				4'd3:    regAlarm <= apbIn.pwdata[0];
				default: ; // Unmapped
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Pin checks

	assert property (@(posedge CLK) reset && $past(reset) |-> hsPin && vsPin && colorOut == 12'h000)
		else begin
			errCount++;
			$display("error %0t: outputs not idle during reset", $time);
		end

	assert property (@(posedge CLK) disable iff (reset) colorOut == expColor)
		else begin
			errCount++;
			$display("error %0t: COLOR_OUT %h, expected %h at x %0d y %0d", $time,
				$sampled(colorOut), $sampled(expColor), $sampled(outX), $sampled(outY));
		end

	assert property (@(posedge CLK) disable iff (reset) hsPin == expHs && vsPin == expVs)
		else begin
			errCount++;
			$display("error %0t: HS %b VS %b, expected %b %b at x %0d y %0d", $time,
				$sampled(hsPin), $sampled(vsPin), $sampled(expHs), $sampled(expVs),
				$sampled(outX), $sampled(outY));
		end

	////////////////////////////////////////////////////////////
	// Stimulus helpers

	function automatic logic [31:0] nextRandom();
		rngState = rngState * 32'd1103515245 + 32'd12345;
		return rngState;
	endfunction

	// Six BCD digits, about one in eight above 9
	function automatic logic [23:0] randomBcd();
		logic [23:0] v;
		logic [31:0] r;
		int          i;
		v = '0;
		for (i = 0; i < 6; i++) begin
			r = nextRandom();
			if (r[22:20] == 3'd0)
				v[4 * i +: 4] = 4'(10 + r[31:16] % 6);
			else
				v[4 * i +: 4] = 4'(r[31:16] % 10);
		end
		return v;
	endfunction

	task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] want);
		assert (got === want)
			else begin
				errCount++;
				$display("error %0t: %s is %h, expected %h", $time, what, got, want);
			end
	endtask

	// Setup then access phase, response sampled mid access
	task automatic apbTransfer(input logic write, input logic [3:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(posedge CLK);
		#1;
		apbIn.psel    = 1'b1;
		apbIn.penable = 1'b0;
		apbIn.pwrite  = write;
		apbIn.paddr   = addr;
		apbIn.pwdata  = wdata;
		@(posedge CLK);
		#1;
		apbIn.penable = 1'b1;
		#3;
		rdata = apbOut.prdata;
		err   = apbOut.pslverr;
		checkValue("pready", 32'(apbOut.pready), 32'd1); // No wait states
		@(posedge CLK); // Access edge
		#1;
		apbIn = '0;
	endtask

	task automatic writeReg(input logic [3:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic        err;
		apbTransfer(1'b1, addr, data, rd, err);
		checkValue("pslverr on write", 32'(err), 32'd0);
	endtask

	task automatic finishTest(input string name);
		int errs;
		errs = errCount - testErrStart;
		if (errs == 0)
			testsPassed++;
		else
			testsFailed++;
		$display("Test %s %s with %0d errors", name, (errs == 0) ? "passed" : "failed", errs);
		testErrStart = errCount;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [23:0] dateVal;
		logic [23:0] clockVal;
		logic [23:0] timerVal;
		logic [31:0] rd;
		logic        err;
		int          round;
		reset = 1'b1;
		apbIn = '0;
		repeat (3) @(posedge CLK);
		#1;
		reset = 1'b0;

		repeat (FrameCycles) @(posedge CLK); // Idle outputs, then one frame of syncs
		finishTest("reset and sync");

		writeReg(4'd0, 32'h00FF_FFFF); // All digits blank so only background shows
		writeReg(4'd1, 32'h00FF_FFFF);
		writeReg(4'd2, 32'h00FF_FFFF);
		repeat (FrameCycles) @(posedge CLK);
		finishTest("background");

		for (round = 0; round < 2; round++) begin
			dateVal  = randomBcd();
			clockVal = randomBcd();
			timerVal = randomBcd();
			if (round == 1)
				timerVal[3:0] = 4'hE; // At least one blank cell
			writeReg(4'd0, {8'h00, dateVal});
			writeReg(4'd1, {8'h00, clockVal});
			writeReg(4'd2, {8'h00, timerVal});
			repeat (FrameCycles) @(posedge CLK);
		end
		finishTest("digits");

		writeReg(4'd3, 32'd1);
		repeat (FrameCycles) @(posedge CLK);
		writeReg(4'd3, 32'd0);
		repeat (FrameCycles) @(posedge CLK);
		finishTest("alarm");

		apbTransfer(1'b1, 4'd5, 32'h0012_3456, rd, err);
		checkValue("pslverr on write to 5", 32'(err), 32'd1);
		apbTransfer(1'b0, 4'd5, 32'd0, rd, err);
		checkValue("pslverr on read of 5", 32'(err), 32'd1);
		checkValue("read data at 5", rd, 32'd0);
		apbTransfer(1'b0, 4'd0, 32'd0, rd, err);
		checkValue("date", rd, {8'h00, dateVal});
		apbTransfer(1'b0, 4'd1, 32'd0, rd, err);
		checkValue("clock", rd, {8'h00, clockVal});
		apbTransfer(1'b0, 4'd2, 32'd0, rd, err);
		checkValue("timer", rd, {8'h00, timerVal});
		checkValue("pslverr on mapped read", 32'(err), 32'd0);
		apbTransfer(1'b0, 4'd3, 32'd0, rd, err);
		checkValue("control", rd, 32'd0);
		finishTest("APB access");

		$display("Tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errCount);
		if (testsFailed == 0 && errCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		while (cycleCount < TimeoutCycles)
			@(posedge CLK);
		$display("Timeout after %0d cycles, the tests did not finish", TimeoutCycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: clockDisplay.f
src/clockDisplayPkg.sv
src/vgaTiming.sv
src/fieldDecoder.sv
src/timeRegisters.sv
src/glyphRenderer.sv
src/clockDisplay.sv
bench/tbClockDisplay.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and scan the log for failure
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f clockDisplay.f \
	--top-module tbClockDisplay -o simClockDisplay > build.log 2>&1 &&
./obj_dir/simClockDisplay > sim.log 2>&1
status=$?
[ -f sim.log ] && cat sim.log
[ $status -eq 0 ] && ! grep -q "TEST RESULT: FAIL" sim.log &&
	echo "Simulation passed" ||
	{ echo "Simulation failed, see build.log and sim.log"; exit 1; }
exit 0
